//--- tests/uart_master_input.txt
# columns: wr addr data corrupt, all hex
# wr 1 writes data to addr, wr 0 reads addr and data is the expected reply
1 05 3c 0
1 7f a5 0
0 05 3c 0
0 7f a5 0
0 12 00 0
1 12 ff 0
0 12 ff 1
1 00 01 0
0 00 01 0
1 05 80 0
0 05 80 1
0 33 00 0
1 40 00 0
0 40 00 0
0 7f a5 1
1 2a 5a 0

//--- build.f
+incdir+hw
hw/uart_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_cmd_ctrl.sv
hw/uart_master.sv
tests/tb_clk_gen.sv
tests/uart_slave_model.sv
tests/uart_master_tb.sv

//--- Bender.yml
package:
  name: uart_master

sources:
  - include_dirs:
      - hw
    files:
      - hw/uart_pkg.sv
      - hw/uart_tx.sv
      - hw/uart_rx.sv
      - hw/uart_cmd_ctrl.sv
      - hw/uart_master.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_clk_gen.sv
      - tests/uart_slave_model.sv
      - tests/uart_master_tb.sv

//--- tests/uart_master_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_macros.svh"

module uart_master_tb;
  import uart_pkg::*;

  localparam int per_txn = 30 * `UART_CLKS_PER_BIT + `UART_BYTE_GAP;

  logic       clk;
  logic       rst_n;
  uart_cmd_t  cmd;
  logic       cmd_valid;
  logic       cmd_ready;
  uart_rsp_t  rsp;
  logic       rsp_valid;
  logic       rsp_ready;
  logic       tx;
  logic       rx;
  logic       corrupt;
  uart_byte_t frame_byte;
  logic       frame_parity_ok;
  logic       frame_valid;

  uart_byte_t  shadow [128];
  uart_byte_t  exp_frames [$];
  int          q_wr [$];
  int          q_addr [$];
  int          q_data [$];
  int          q_cor [$];
  logic [15:0] lfsr_q;
  logic        read_pending;
  int          cycles;
  int          cycle_limit;
  int          read_count;
  int          rsp_count;

  tb_clk_gen tb_clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_master uart_master_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rx        (rx),
    .tx        (tx)
  );

  uart_slave_model uart_slave_model_i (
    .clk             (clk),
    .tx              (tx),
    .corrupt         (corrupt),
    .rx              (rx),
    .frame_byte      (frame_byte),
    .frame_parity_ok (frame_parity_ok),
    .frame_valid     (frame_valid)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_stall(output int n);
    n = 0;
    repeat (2)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      n = (n << 1) | int'(lfsr_q[0]);
    end
  endtask

  // called on a rising edge and returns on the accepting edge
  task automatic send_cmd(input logic wr, input uart_addr_t addr, input uart_byte_t data);
    uart_cmd_t c;
    c.write = wr;
    c.addr  = addr;
    c.data  = data;
    cmd       <= c;
    cmd_valid <= 1'b1;
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic run_write(input uart_addr_t addr, input uart_byte_t data);
    exp_frames.push_back({1'b1, addr});
    exp_frames.push_back(data);
    shadow[addr] = data;
    send_cmd(1'b1, addr, data);
    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
  endtask

  task automatic run_read(input uart_addr_t addr, input uart_byte_t exp_file, input logic flip);
    uart_rsp_t held;
    int        stall;
    if (exp_file !== shadow[addr])
      abort_run($sformatf("data file expects 0x%h at 0x%h but 0x%h was written last",
                          exp_file, addr, shadow[addr]));
    corrupt <= flip;
    exp_frames.push_back({1'b0, addr});
    read_count++;
    send_cmd(1'b0, addr, 8'h00);
    read_pending <= 1'b1;
    while (!rsp_valid)
      @(posedge clk);
    held = rsp;
    check_byte("rsp.data", held.data, shadow[addr]);
    check_flag("rsp.parity_err", held.parity_err, flip);
    next_stall(stall);
    repeat (stall)
    begin
      @(posedge clk);
      check_flag("rsp_valid", rsp_valid, 1'b1);
      check_byte("rsp.data", rsp.data, held.data);
      check_flag("rsp.parity_err", rsp.parity_err, held.parity_err);
      check_flag("cmd_ready", cmd_ready, 1'b0);
    end
    rsp_ready <= 1'b1;
    @(posedge clk);
    check_flag("rsp_valid", rsp_valid, 1'b1);
    check_byte("rsp.data", rsp.data, held.data);
    rsp_ready    <= 1'b0;
    read_pending <= 1'b0;
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
      abort_run($sformatf("timeout after %0d cycles, transactions did not finish", cycles));
    if (rst_n)
    begin
      if (rsp_valid && rsp_ready)
        rsp_count <= rsp_count + 1;
      if (rsp_valid && !read_pending)
        abort_run("rsp_valid went high with no read outstanding");
      if (cmd_ready)
        check_flag("tx", tx, 1'b1);
      if (frame_valid)
      begin
        if (!frame_parity_ok)
          abort_run("slave model saw a tx frame with wrong parity");
        else if (exp_frames.size() == 0)
          abort_run("tx frame seen while no frame was expected");
        else
          check_byte("tx frame", frame_byte, exp_frames.pop_front());
      end
    end
  end

  initial
  begin
    int    fd;
    int    n;
    int    f_wr;
    int    f_addr;
    int    f_data;
    int    f_cor;
    string line;
    cmd          = '0;
    cmd_valid    = 1'b0;
    rsp_ready    = 1'b0;
    corrupt      = 1'b0;
    read_pending = 1'b0;
    lfsr_q       = 16'd5;
    cycles       = 0;
    cycle_limit  = 0;
    read_count   = 0;
    rsp_count    = 0;
    for (int i = 0; i < 128; i++)
      shadow[i] = '0;

    fd = $fopen("tests/uart_master_input.txt", "r");
    if (fd == 0)
      abort_run("cannot open tests/uart_master_input.txt");
    while ($fgets(line, fd) != 0)
    begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      n = $sscanf(line, "%h %h %h %h", f_wr, f_addr, f_data, f_cor);
      if (n != 4)
        abort_run({"malformed line in data file: ", line});
      q_wr.push_back(f_wr);
      q_addr.push_back(f_addr);
      q_data.push_back(f_data);
      q_cor.push_back(f_cor);
    end
    $fclose(fd);
    cycle_limit = q_wr.size() * per_txn;

    wait (rst_n === 1'b1);
    check_flag("cmd_ready", cmd_ready, 1'b0);
    check_flag("rsp_valid", rsp_valid, 1'b0);
    check_flag("tx", tx, 1'b1);
    repeat (2) @(posedge clk);
    check_flag("cmd_ready", cmd_ready, 1'b1);

    for (int i = 0; i < q_wr.size(); i++)
    begin
      if (q_wr[i] != 0)
        run_write(uart_addr_t'(q_addr[i]), uart_byte_t'(q_data[i]));
      else
        run_read(uart_addr_t'(q_addr[i]), uart_byte_t'(q_data[i]), q_cor[i] != 0);
    end

    @(posedge clk);
    while (!cmd_ready)
      @(posedge clk);
    repeat (4) @(posedge clk);
    if (rsp_count != read_count || exp_frames.size() != 0)
      abort_run($sformatf("%0d responses for %0d reads, %0d tx frames never seen",
                          rsp_count, read_count, exp_frames.size()));
    else
    begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- tests/uart_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_macros.svh"

module uart_slave_model (
  input  wire                  clk,
  input  wire                  tx,
  input  wire                  corrupt,
  output logic                 rx,
  output uart_pkg::uart_byte_t frame_byte,
  output logic                 frame_parity_ok,
  output logic                 frame_valid
);
  import uart_pkg::*;

  localparam int clks = `UART_CLKS_PER_BIT;

  uart_byte_t regs [128];
  uart_byte_t bits;
  logic       par;
  logic       have_addr;
  uart_addr_t addr_q;

  // returns in the middle of the stop bit
  task automatic receive_frame(output uart_byte_t data, output logic parity);
    @(posedge clk);
    while (tx !== 1'b0)
      @(posedge clk);
    // one cycle into the start bit here
    repeat (clks / 2 - 1) @(posedge clk);
    for (int i = 0; i < 8; i++)
    begin
      repeat (clks) @(posedge clk);
      data[i] = tx;
    end
    repeat (clks) @(posedge clk);
    parity = tx;
    repeat (clks) @(posedge clk);
  endtask

  task automatic send_frame(input uart_byte_t data, input logic flip);
    logic [10:0] frame;
    frame = {1'b1, (~^data) ^ flip, data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx <= frame[i];
      repeat (clks) @(posedge clk);
    end
  endtask

  initial
  begin
    rx              = 1'b1;
    frame_byte      = '0;
    frame_parity_ok = 1'b1;
    frame_valid     = 1'b0;
    have_addr       = 1'b0;
    for (int i = 0; i < 128; i++)
      regs[i] = '0;
    forever
    begin
      receive_frame(bits, par);
      frame_byte      <= bits;
      frame_parity_ok <= ^{bits, par};
      frame_valid     <= 1'b1;
      @(posedge clk);
      frame_valid <= 1'b0;
      if (have_addr)
      begin
        regs[addr_q] = bits;
        have_addr    = 1'b0;
      end
      else if (bits[7])
      begin
        addr_q    = bits[6:0];
        have_addr = 1'b1;
      end
      else
      begin
        // short idle before the reply
        repeat (2 * clks - 1) @(posedge clk);
        send_frame(regs[bits[6:0]], corrupt);
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever
      #2 clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/uart_master.sv
`timescale 1ns/10ps
`default_nettype none

module uart_master (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire uart_pkg::uart_cmd_t cmd,
  input  wire                      cmd_valid,
  output wire                      cmd_ready,
  output uart_pkg::uart_rsp_t      rsp,
  output wire                      rsp_valid,
  input  wire                      rsp_ready,
  input  wire                      rx,
  output wire                      tx
);
  import uart_pkg::*;

  uart_byte_t tx_byte;
  logic       tx_valid;
  logic       tx_ready;
  uart_byte_t rx_byte;
  logic       rx_parity_err;
  logic       rx_valid;

  uart_cmd_ctrl uart_cmd_ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .rsp           (rsp),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .tx_byte       (tx_byte),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_valid      (rx_valid)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_rx uart_rx_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_byte       (rx_byte),
    .rx_parity_err (rx_parity_err),
    .rx_valid      (rx_valid)
  );

endmodule

`default_nettype wire

//--- hw/uart_cmd_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_macros.svh"

module uart_cmd_ctrl (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire uart_pkg::uart_cmd_t  cmd,
  input  wire                       cmd_valid,
  output logic                      cmd_ready,
  output uart_pkg::uart_rsp_t       rsp,
  output logic                      rsp_valid,
  input  wire                       rsp_ready,
  output uart_pkg::uart_byte_t      tx_byte,
  output logic                      tx_valid,
  input  wire                       tx_ready,
  input  wire uart_pkg::uart_byte_t rx_byte,
  input  wire                       rx_parity_err,
  input  wire                       rx_valid
);
  import uart_pkg::*;

  localparam int gap_w = $clog2(`UART_BYTE_GAP);
  localparam logic [gap_w-1:0] gap_last = gap_w'(`UART_BYTE_GAP - 1);

  ctrl_state_t      state_q;
  ctrl_state_t      state_d;
  uart_cmd_t        cmd_q;
  uart_rsp_t        rsp_q;
  logic [gap_w-1:0] gap_cnt;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ctrl_idle:
        if (cmd_valid && cmd_ready)
          state_d = ctrl_send_addr;
      ctrl_send_addr:
        if (tx_ready)
          state_d = ctrl_wait_addr;
      // framer busy until the address frame is out
      ctrl_wait_addr:
        if (tx_ready)
          state_d = cmd_q.write ? ctrl_gap : ctrl_await_reply;
      ctrl_gap:
        if (gap_cnt == gap_last)
          state_d = ctrl_send_data;
      ctrl_send_data:
        if (tx_ready)
          state_d = ctrl_wait_data;
      ctrl_wait_data:
        if (tx_ready)
          state_d = ctrl_idle;
      ctrl_await_reply:
        if (rx_valid)
          state_d = ctrl_respond;
      ctrl_respond:
        if (rsp_ready)
          state_d = ctrl_idle;
      default:
        state_d = ctrl_idle;
    endcase
  end

  // cmd_ready registered so it stays low through reset
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= ctrl_idle;
      cmd_ready <= 1'b0;
      gap_cnt   <= '0;
    end
    else
    begin
      state_q   <= state_d;
      cmd_ready <= (state_d == ctrl_idle);
      if (state_q == ctrl_gap)
        gap_cnt <= gap_cnt + 1'b1;
      else
        gap_cnt <= '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_valid && cmd_ready)
      cmd_q <= cmd;
    if (state_q == ctrl_await_reply && rx_valid)
    begin
      rsp_q.data       <= rx_byte;
      rsp_q.parity_err <= rx_parity_err;
    end
  end

  assign tx_valid  = (state_q == ctrl_send_addr) || (state_q == ctrl_send_data);
  assign tx_byte   = (state_q == ctrl_send_data) ? cmd_q.data : {cmd_q.write, cmd_q.addr};
  assign rsp_valid = (state_q == ctrl_respond);
  assign rsp       = rsp_q;

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_macros.svh"

module uart_rx (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  rx,
  output uart_pkg::uart_byte_t rx_byte,
  output logic                 rx_parity_err,
  output logic                 rx_valid
);
  import uart_pkg::*;

  typedef enum logic {
    rx_idle,
    rx_frame
  } rx_state_t;

  localparam uart_baud_cnt_t last_cnt   = uart_baud_cnt_t'(`UART_CLKS_PER_BIT - 1);
  localparam uart_baud_cnt_t sample_cnt = uart_baud_cnt_t'(`UART_SAMPLE_POINT);

  logic [1:0]     rx_sync;
  logic           rx_prev;
  logic           fall_edge;
  logic           sample_now;
  rx_state_t      state_q;
  uart_baud_cnt_t baud_cnt;
  logic [3:0]     bit_idx;
  uart_byte_t     shift_q;

  assign fall_edge  = rx_prev & ~rx_sync[1];
  assign sample_now = (state_q == rx_frame) && (baud_cnt == sample_cnt);
  assign rx_byte    = shift_q;

  // two-flop synchronizer plus edge history, line idles high
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync <= 2'b11;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_sync[1];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= rx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (state_q == rx_idle)
      begin
        // edge cycle counts as cycle 0 of the start bit
        if (fall_edge)
        begin
          state_q  <= rx_frame;
          baud_cnt <= uart_baud_cnt_t'(1);
          bit_idx  <= '0;
        end
      end
      else
      begin
        if (baud_cnt == last_cnt)
        begin
          baud_cnt <= '0;
          bit_idx  <= bit_idx + 4'd1;
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
        // glitch, start bit gone by mid-bit
        if (sample_now && bit_idx == 4'd0 && rx_sync[1])
          state_q <= rx_idle;
        // middle of stop bit
        if (sample_now && bit_idx == 4'd10)
        begin
          state_q  <= rx_idle;
          rx_valid <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample_now && bit_idx >= 4'd1 && bit_idx <= 4'd8)
      shift_q <= {rx_sync[1], shift_q[7:1]};
    else if (sample_now && bit_idx == 4'd9)
      rx_parity_err <= ~^{shift_q, rx_sync[1]};
  end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_macros.svh"

module uart_tx (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire uart_pkg::uart_byte_t tx_byte,
  input  wire                       tx_valid,
  output logic                      tx_ready,
  output logic                      tx
);
  import uart_pkg::*;

  typedef enum logic {
    tx_idle,
    tx_send
  } tx_state_t;

  localparam uart_baud_cnt_t last_cnt = uart_baud_cnt_t'(`UART_CLKS_PER_BIT - 1);

  tx_state_t      state_q;
  uart_baud_cnt_t baud_cnt;
  logic [3:0]     bit_idx;
  uart_byte_t     shift_q;
  logic           parity_q;
  logic           bit_done;

  assign tx_ready = (state_q == tx_idle);
  assign bit_done = (baud_cnt == last_cnt);

  // bit index 0 start, 1..8 data, 9 parity, 10 stop
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q  <= tx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (state_q == tx_idle)
    begin
      if (tx_valid)
      begin
        state_q  <= tx_send;
        baud_cnt <= '0;
        bit_idx  <= '0;
        tx       <= 1'b0;
      end
    end
    else if (bit_done)
    begin
      baud_cnt <= '0;
      bit_idx  <= bit_idx + 4'd1;
      case (bit_idx)
        4'd8:    tx <= parity_q;
        4'd9:    tx <= 1'b1;
        4'd10:   state_q <= tx_idle;
        default: tx <= shift_q[0];
      endcase
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // lsb goes out first, odd parity over the byte
  always_ff @(posedge clk)
  begin
    if (tx_ready && tx_valid)
    begin
      shift_q  <= tx_byte;
      parity_q <= ~^tx_byte;
    end
    else if (state_q == tx_send && bit_done && bit_idx < 4'd8)
    begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_pkg.sv
`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

  typedef logic [7:0] uart_byte_t;
  typedef logic [6:0] uart_addr_t;
  typedef logic [$clog2(`UART_CLKS_PER_BIT + 1)-1:0] uart_baud_cnt_t;

  // write flag sits in the top bit
  typedef struct packed {
    logic       write;
    uart_addr_t addr;
    uart_byte_t data;
  } uart_cmd_t;

  typedef struct packed {
    uart_byte_t data;
    logic       parity_err;
  } uart_rsp_t;

  typedef enum logic [2:0] {
    ctrl_idle,
    ctrl_send_addr,
    ctrl_wait_addr,
    ctrl_gap,
    ctrl_send_data,
    ctrl_wait_data,
    ctrl_await_reply,
    ctrl_respond
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/uart_macros.svh
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// clock cycles per serial bit
`define UART_CLKS_PER_BIT 16

// rx sample point, counted in cycles into the bit
`define UART_SAMPLE_POINT 8

// idle cycles between address and data byte of a write
`define UART_BYTE_GAP 20

`endif
